// File: hw/decodePkg.sv
// Opcodes, field types, select enums and the control word shared by the decoder RTL and testbench
`default_nettype none

package decodePkg;

    localparam int WordSize = 32;
    localparam int ByteEnWidth = 4;

    typedef logic [WordSize-1:0] instrWord;
    typedef logic [6:0] opcodeField;
    typedef logic [2:0] funct3Field;
    typedef logic [6:0] funct7Field;
    typedef logic [ByteEnWidth-1:0] byteEnable;

    // RV32I major opcodes
    localparam opcodeField OpcodeOp = 7'b0110011;
    localparam opcodeField OpcodeOpImm = 7'b0010011;
    localparam opcodeField OpcodeLoad = 7'b0000011;
    localparam opcodeField OpcodeStore = 7'b0100011;
    localparam opcodeField OpcodeLui = 7'b0110111;
    localparam opcodeField OpcodeAuipc = 7'b0010111;
    localparam opcodeField OpcodeJal = 7'b1101111;
    localparam opcodeField OpcodeJalr = 7'b1100111;
    localparam opcodeField OpcodeBranch = 7'b1100011;

    // funct7 patterns for OP and the shift immediates
    localparam funct7Field Funct7Base = 7'b0000000;
    localparam funct7Field Funct7Alt = 7'b0100000;

    typedef enum logic [1:0] {
        PcPlus4, JumpRel, JumpReg, BranchCond
    } pcSrc;

    typedef enum logic [2:0] {
        NoBranch, Beq, Bne, Blt, Bge, Bltu, Bgeu
    } branchCond;

    typedef enum logic [2:0] {
        ImmI, ImmS, ImmB, ImmU, ImmJ, ImmShamt
    } immSrc;

    // Return address literal is prefixed to stay apart from the pcSrc value
    typedef enum logic [1:0] {
        PassNone, LoadImm, PcPlusImm, PassPcPlus4
    } passthroughSrc;

    typedef enum logic {SrcRs2, SrcImm} aluSrcB;

    typedef enum logic [3:0] {
        Add, Sub, Or, And, Xor, Sll, Slt, Sltu, Srl, Sra
    } aluOperation;

    typedef enum logic {ComputeAlu, ComputePass} computeSrc;

    typedef enum logic {ResultCompute, ResultMemory} resultSrc;

    typedef enum logic [2:0] {
        NoTrunc, TruncByte, TruncHalf, TruncWord, TruncByteU, TruncHalfU
    } truncSrc;

    typedef struct packed {
        logic          regWrite;
        logic          memEn;
        logic          memWrite;
        byteEnable     byteEn;
        pcSrc          pcSel;
        branchCond     branchSel;
        immSrc         immSel;
        passthroughSrc passSel;
        aluSrcB        srcBSel;
        aluOperation   aluOp;
        computeSrc     computeSel;
        resultSrc      resultSel;
        truncSrc       truncSel;
    } controlWord;

    // Every enable cleared, every select at its first value
    localparam controlWord ZeroCtrl = '0;

endpackage

`default_nettype wire

// File: hw/aluOpDecoder.sv
// Combinational decoder for OP and OP-IMM instructions, instantiated by the top-level decoder
`timescale 1ns/1ps
`default_nettype none

module aluOpDecoder import decodePkg::*; (
    input  opcodeField opcode,
    input  funct3Field funct3,
    input  funct7Field funct7,
    output logic       hit,
    output controlWord ctrl
);

    logic isOp;
    logic isOpImm;
    logic legal;
    aluOperation op;
    immSrc imm;

    assign isOp = (opcode == OpcodeOp);
    assign isOpImm = (opcode == OpcodeOpImm);
    assign hit = isOp | isOpImm;

    always_comb begin
        legal = 1'b0;
        op = Add;
        imm = ImmI;
        if (isOp) begin
            legal = 1'b1;
            case ({funct7, funct3})
                {Funct7Base, 3'b000}: op = Add;
                {Funct7Alt, 3'b000}: op = Sub;
                {Funct7Base, 3'b001}: op = Sll;
                {Funct7Base, 3'b010}: op = Slt;
                {Funct7Base, 3'b011}: op = Sltu;
                {Funct7Base, 3'b100}: op = Xor;
                {Funct7Base, 3'b101}: op = Srl;
                {Funct7Alt, 3'b101}: op = Sra;
                {Funct7Base, 3'b110}: op = Or;
                {Funct7Base, 3'b111}: op = And;
                default: legal = 1'b0;
            endcase
        end else if (isOpImm) begin
            legal = 1'b1;
            case (funct3)
                3'b000: op = Add;
                3'b010: op = Slt;
                3'b011: op = Sltu;
                3'b100: op = Xor;
                3'b110: op = Or;
                3'b111: op = And;
                // Shamt sits in rs2 slot, upper bits must match the shift pattern
                3'b001: begin
                    imm = ImmShamt;
                    op = Sll;
                    legal = (funct7 == Funct7Base);
                end
                3'b101: begin
                    imm = ImmShamt;
                    if (funct7 == Funct7Alt) begin
                        op = Sra;
                    end else if (funct7 == Funct7Base) begin
                        op = Srl;
                    end else begin
                        legal = 1'b0;
                    end
                end
            endcase
        end
    end

    always_comb begin
        ctrl = ZeroCtrl;
        if (legal) begin
            ctrl.regWrite = 1'b1;
            ctrl.pcSel = PcPlus4;
            ctrl.immSel = imm;
            ctrl.srcBSel = isOpImm ? SrcImm : SrcRs2;
            ctrl.aluOp = op;
            ctrl.computeSel = ComputeAlu;
            ctrl.resultSel = ResultCompute;
        end
    end

endmodule

`default_nettype wire

// File: hw/memOpDecoder.sv
// Combinational decoder for LOAD and STORE instructions, instantiated by the top-level decoder
`timescale 1ns/1ps
`default_nettype none

module memOpDecoder import decodePkg::*; (
    input  opcodeField opcode,
    input  funct3Field funct3,
    output logic       hit,
    output controlWord ctrl
);

    logic isLoad;
    logic isStore;

    assign isLoad = (opcode == OpcodeLoad);
    assign isStore = (opcode == OpcodeStore);
    assign hit = isLoad | isStore;

    always_comb begin
        ctrl = ZeroCtrl;
        // Address is rs1 plus offset for both
        ctrl.srcBSel = SrcImm;
        ctrl.aluOp = Add;
        ctrl.computeSel = ComputeAlu;
        if (isLoad) begin
            ctrl.regWrite = 1'b1;
            ctrl.memEn = 1'b1;
            ctrl.immSel = ImmI;
            ctrl.resultSel = ResultMemory;
            case (funct3)
                3'b000: ctrl.truncSel = TruncByte;
                3'b001: ctrl.truncSel = TruncHalf;
                3'b010: ctrl.truncSel = TruncWord;
                3'b100: ctrl.truncSel = TruncByteU;
                3'b101: ctrl.truncSel = TruncHalfU;
                default: ctrl = ZeroCtrl;
            endcase
        end else if (isStore) begin
            ctrl.memEn = 1'b1;
            ctrl.memWrite = 1'b1;
            ctrl.immSel = ImmS;
            case (funct3)
                3'b000: ctrl.byteEn = 4'b0001;
                3'b001: ctrl.byteEn = 4'b0011;
                3'b010: ctrl.byteEn = 4'b1111;
                default: ctrl = ZeroCtrl;
            endcase
        end else begin
            ctrl = ZeroCtrl;
        end
    end

endmodule

`default_nettype wire

// File: hw/flowOpDecoder.sv
// Combinational decoder for branches, JAL, JALR, LUI and AUIPC, instantiated by the top-level decoder
`timescale 1ns/1ps
`default_nettype none

module flowOpDecoder import decodePkg::*; (
    input  opcodeField opcode,
    input  funct3Field funct3,
    output logic       hit,
    output controlWord ctrl
);

    always_comb begin
        hit = 1'b1;
        ctrl = ZeroCtrl;
        case (opcode)
            OpcodeBranch: begin
                // Comparison runs through the ALU, target is pc plus offset
                ctrl.pcSel = BranchCond;
                ctrl.immSel = ImmB;
                ctrl.srcBSel = SrcRs2;
                ctrl.aluOp = Sub;
                case (funct3)
                    3'b000: ctrl.branchSel = Beq;
                    3'b001: ctrl.branchSel = Bne;
                    3'b100: ctrl.branchSel = Blt;
                    3'b101: ctrl.branchSel = Bge;
                    3'b110: ctrl.branchSel = Bltu;
                    3'b111: ctrl.branchSel = Bgeu;
                    default: ctrl = ZeroCtrl;
                endcase
            end
            OpcodeJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.pcSel = JumpRel;
                ctrl.immSel = ImmJ;
                ctrl.passSel = PassPcPlus4;
                ctrl.computeSel = ComputePass;
            end
            OpcodeJalr: begin
                // Target is rs1 plus immediate
                ctrl.regWrite = 1'b1;
                ctrl.pcSel = JumpReg;
                ctrl.immSel = ImmI;
                ctrl.srcBSel = SrcImm;
                ctrl.passSel = PassPcPlus4;
                ctrl.computeSel = ComputePass;
            end
            OpcodeLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.immSel = ImmU;
                ctrl.passSel = LoadImm;
                ctrl.computeSel = ComputePass;
            end
            OpcodeAuipc: begin
                ctrl.regWrite = 1'b1;
                ctrl.immSel = ImmU;
                ctrl.passSel = PcPlusImm;
                ctrl.computeSel = ComputePass;
            end
            default: begin
                hit = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/instrDecode.sv
// Top-level RV32I decoder giving one registered control word per instruction strobe
`timescale 1ns/1ps
`default_nettype none

module instrDecode import decodePkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       instrValid,
    input  instrWord   instr,
    output logic       ctrlValid,
    output controlWord ctrl
);

    opcodeField opcode;
    funct3Field funct3;
    funct7Field funct7;

    logic aluHit;
    logic memHit;
    logic flowHit;
    controlWord aluCtrl;
    controlWord memCtrl;
    controlWord flowCtrl;
    controlWord nextCtrl;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    aluOpDecoder aluDecoder (
        .opcode(opcode),
        .funct3(funct3),
        .funct7(funct7),
        .hit(aluHit),
        .ctrl(aluCtrl)
    );

    memOpDecoder memDecoder (
        .opcode(opcode),
        .funct3(funct3),
        .hit(memHit),
        .ctrl(memCtrl)
    );

    flowOpDecoder flowDecoder (
        .opcode(opcode),
        .funct3(funct3),
        .hit(flowHit),
        .ctrl(flowCtrl)
    );

    // Opcodes are disjoint so at most one decoder hits
    always_comb begin
        if (aluHit) begin
            nextCtrl = aluCtrl;
        end else if (memHit) begin
            nextCtrl = memCtrl;
        end else if (flowHit) begin
            nextCtrl = flowCtrl;
        end else begin
            nextCtrl = ZeroCtrl;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlValid <= 1'b0;
            ctrl <= ZeroCtrl;
        end else begin
            ctrlValid <= instrValid;
            // Held until the next strobe
            if (instrValid) begin
                ctrl <= nextCtrl;
            end
        end
    end

endmodule

`default_nettype wire

// File: test/instrDecodeProps.sv
// Concurrent handshake and enable checks on the decoder, bound into every instrDecode instance
`timescale 1ns/1ps
`default_nettype none

module instrDecodeProps import decodePkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       instrValid,
    input logic       ctrlValid,
    input controlWord ctrl
);

    int propErrors = 0;
    logic started;

    // Set by the first strobe after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            started <= 1'b0;
        end else if (instrValid) begin
            started <= 1'b1;
        end
    end

    resetClears: assert property (@(posedge clk)
        reset |=> !ctrlValid && !ctrl.regWrite && !ctrl.memEn && !ctrl.memWrite)
        else begin
            propErrors++;
            $error("Outputs active in the cycle after reset");
        end

    idleUntilStrobe: assert property (@(posedge clk)
        !reset && !started |-> !ctrlValid && !ctrl.regWrite && !ctrl.memEn && !ctrl.memWrite)
        else begin
            propErrors++;
            $error("Outputs active before the first instruction strobe");
        end

    validFollows: assert property (@(posedge clk) disable iff (reset)
        instrValid |=> ctrlValid)
        else begin
            propErrors++;
            $error("No ctrlValid one cycle after instrValid");
        end

    noSpuriousValid: assert property (@(posedge clk) disable iff (reset)
        ctrlValid |-> $past(instrValid))
        else begin
            propErrors++;
            $error("ctrlValid without instrValid in the previous cycle");
        end

    // Control word only moves together with its valid strobe
    holdWithoutValid: assert property (@(posedge clk) disable iff (reset)
        !ctrlValid |-> $stable(ctrl))
        else begin
            propErrors++;
            $error("ctrl changed without ctrlValid");
        end

    storeNoWrite: assert property (@(posedge clk) disable iff (reset)
        ctrlValid && ctrl.memWrite |-> !ctrl.regWrite)
        else begin
            propErrors++;
            $error("Store control word also writes a register");
        end

endmodule

bind instrDecode instrDecodeProps checkProps (
    .clk(clk),
    .reset(reset),
    .instrValid(instrValid),
    .ctrlValid(ctrlValid),
    .ctrl(ctrl)
);

`default_nettype wire

// File: test/instrDecodeTb.sv
// Random-stimulus testbench for instrDecode; compile with build.f and run instrDecodeTb as top
`timescale 1ns/1ps
`default_nettype none

module instrDecodeTb import decodePkg::*; ();

    localparam int NumInstrs = 600;
    localparam int MaxGap = 3;
    localparam int ClkPeriod = 8;
    localparam opcodeField OpcodeList [9] = '{OpcodeOp, OpcodeOpImm, OpcodeLoad, OpcodeStore,
        OpcodeLui, OpcodeAuipc, OpcodeJal, OpcodeJalr, OpcodeBranch};
    localparam aluOperation AluByFunct3 [8] = '{Add, Sll, Slt, Sltu, Xor, Srl, Or, And};
    // NoTrunc and NoBranch mark the reserved funct3 codes
    localparam truncSrc TruncByFunct3 [8] = '{TruncByte, TruncHalf, TruncWord, NoTrunc,
        TruncByteU, TruncHalfU, NoTrunc, NoTrunc};
    localparam branchCond BranchByFunct3 [8] = '{Beq, Bne, NoBranch, NoBranch,
        Blt, Bge, Bltu, Bgeu};

    logic clk;
    logic reset;
    logic instrValid;
    instrWord instr;
    logic ctrlValid;
    controlWord ctrl;

    logic [31:0] rngState;
    instrWord sentQueue [$];
    instrWord sent;
    int errors = 0;

    instrDecode i_instrDecode (
        .clk(clk),
        .reset(reset),
        .instrValid(instrValid),
        .instr(instr),
        .ctrlValid(ctrlValid),
        .ctrl(ctrl)
    );

    function automatic logic [31:0] nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    // Mostly listed opcodes with funct7 biased toward the two defined patterns
    function automatic instrWord buildInstr();
        logic [31:0] pick;
        logic [31:0] fields;
        opcodeField opc;
        funct7Field f7;
        pick = nextRandom();
        fields = nextRandom();
        opc = (pick[3:0] == 4'd0) ? fields[6:0] : OpcodeList[pick[31:8] % 9];
        case (pick[5:4])
            2'd0, 2'd1: f7 = 7'b0000000;
            2'd2: f7 = 7'b0100000;
            default: f7 = fields[31:25];
        endcase
        return {f7, fields[24:7], opc};
    endfunction

    // Expected control word with unused selects left at their first value
    function automatic controlWord expectCtrl(instrWord w);
        controlWord c;
        funct3Field f3;
        logic alt;
        logic shift;
        c = '0;
        f3 = w[14:12];
        alt = (w[31:25] == 7'b0100000);
        shift = (f3 == 3'b001) || (f3 == 3'b101);
        case (w[6:0])
            OpcodeOp: begin
                if (w[31:25] == 7'b0 || (alt && (f3 == 3'b000 || f3 == 3'b101))) begin
                    c.regWrite = 1'b1;
                    c.aluOp = !alt ? AluByFunct3[f3] : (f3 == 3'b000 ? Sub : Sra);
                end
            end
            OpcodeOpImm: begin
                if (!shift || w[31:25] == 7'b0 || (alt && f3 == 3'b101)) begin
                    c.regWrite = 1'b1;
                    c.srcBSel = SrcImm;
                    c.immSel = shift ? ImmShamt : ImmI;
                    c.aluOp = (shift && alt) ? Sra : AluByFunct3[f3];
                end
            end
            OpcodeLoad: begin
                if (TruncByFunct3[f3] != NoTrunc) begin
                    c.regWrite = 1'b1;
                    c.memEn = 1'b1;
                    c.srcBSel = SrcImm;
                    c.resultSel = ResultMemory;
                    c.truncSel = TruncByFunct3[f3];
                end
            end
            OpcodeStore: begin
                if (f3 < 3'd3) begin
                    c.memEn = 1'b1;
                    c.memWrite = 1'b1;
                    // 1, 2 or 4 low bytes
                    c.byteEn = byteEnable'((1 << (1 << f3)) - 1);
                    c.srcBSel = SrcImm;
                    c.immSel = ImmS;
                end
            end
            OpcodeBranch: begin
                if (BranchByFunct3[f3] != NoBranch) begin
                    c.pcSel = BranchCond;
                    c.immSel = ImmB;
                    c.aluOp = Sub;
                    c.branchSel = BranchByFunct3[f3];
                end
            end
            OpcodeJal, OpcodeJalr: begin
                c.regWrite = 1'b1;
                c.pcSel = (w[6:0] == OpcodeJal) ? JumpRel : JumpReg;
                c.immSel = (w[6:0] == OpcodeJal) ? ImmJ : ImmI;
                c.srcBSel = (w[6:0] == OpcodeJal) ? SrcRs2 : SrcImm;
                c.passSel = PassPcPlus4;
                c.computeSel = ComputePass;
            end
            OpcodeLui, OpcodeAuipc: begin
                c.regWrite = 1'b1;
                c.immSel = ImmU;
                c.passSel = (w[6:0] == OpcodeLui) ? LoadImm : PcPlusImm;
                c.computeSel = ComputePass;
            end
            default: begin
                c = '0;
            end
        endcase
        return c;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        int gap;
        instrWord word;
        reset = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        rngState = 32'h46aec38a;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        // Idle stretch so the post-reset outputs get observed
        repeat (4) @(posedge clk);
        for (int i = 0; i < NumInstrs; i++) begin
            word = buildInstr();
            instrValid <= 1'b1;
            instr <= word;
            sentQueue.push_back(word);
            gap = nextRandom() % (MaxGap + 1);
            @(posedge clk);
            if (gap != 0) begin
                instrValid <= 1'b0;
                // Idle bus carries junk that ctrl must ignore
                instr <= nextRandom();
                repeat (gap) @(posedge clk);
            end
        end
        instrValid <= 1'b0;
        while (sentQueue.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        $display("Errors: %0d output checks, %0d properties", errors,
            i_instrDecode.checkProps.propErrors);
        if (errors == 0 && i_instrDecode.checkProps.propErrors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        if (!reset && ctrlValid === 1'b1) begin
            resultOutstanding: assert (sentQueue.size() != 0) else begin
                errors++;
                $display("Error at %0t: ctrlValid with no instruction outstanding", $time);
            end
            if (sentQueue.size() != 0) begin
                sent = sentQueue.pop_front();
                ctrlMatches: assert (ctrl === expectCtrl(sent)) else begin
                    errors++;
                    $display("MISMATCH at %0t: instr %h gave %p, expected %p",
                        $time, sent, ctrl, expectCtrl(sent));
                end
            end
        end
    end

    initial begin
        #((NumInstrs * (MaxGap + 1) + 100) * ClkPeriod);
        $display("Timeout: decoder results did not drain before the time limit");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hw/decodePkg.sv
hw/aluOpDecoder.sv
hw/memOpDecoder.sv
hw/flowOpDecoder.sv
hw/instrDecode.sv
test/instrDecodeProps.sv
test/instrDecodeTb.sv
